// ==== sim.f ====
+incdir+logic
logic/eeprom_display_pkg.sv
logic/eeprom_byte_reader.sv
logic/tm1650_digit_writer.sv
logic/eeprom_display_top.sv
test/eeprom_display_assertions.sv
test/eeprom_display_tb.sv

// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Veeprom_display_tb
	@out=$$(./obj_dir/Veeprom_display_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

obj_dir/Veeprom_display_tb: sim.f $(wildcard logic/*.sv logic/*.svh test/*.sv)
	verilator --binary --timing --assert --top-module eeprom_display_tb -f sim.f

clean:
	rm -rf obj_dir

// ==== test/eeprom_display_tb.sv ====
`include "eeprom_display_config.svh"

module eeprom_display_tb;

    localparam int jobs = 8;
    localparam int timeout_units = jobs * 28 * 8 * 40;

    logic                          in_clk = 1'b0;
    logic                          in_rst;
    logic                          trigger;
    logic                          bus_done;
    eeprom_display_pkg::bus_byte_t bus_rx_byte;
    logic                          bus_enable;
    eeprom_display_pkg::bus_inst_t bus_inst;
    eeprom_display_pkg::bus_byte_t bus_tx_byte;

    // segment codes for 0 to 9
    eeprom_display_pkg::bus_byte_t seg_table [10] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F
    };
    eeprom_display_pkg::bus_byte_t rx_list [jobs];
    eeprom_display_pkg::bus_inst_t exp_inst [$];
    eeprom_display_pkg::bus_byte_t exp_byte [$];
    eeprom_display_pkg::bus_inst_t want_inst;
    eeprom_display_pkg::bus_byte_t want_byte;
    string                         test_name = "reset";
    int unsigned                   done_count = 0;
    int unsigned                   cmd_count = 0;
    int unsigned                   recv_count = 0;
    logic                          slow_mode = 1'b0;

    eeprom_display_top uut (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .trigger     (trigger),
        .bus_done    (bus_done),
        .bus_rx_byte (bus_rx_byte),
        .bus_enable  (bus_enable),
        .bus_inst    (bus_inst),
        .bus_tx_byte (bus_tx_byte)
    );

    always #20 in_clk = ~in_clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic expect_cmd(input eeprom_display_pkg::bus_inst_t inst,
                              input eeprom_display_pkg::bus_byte_t value);
        exp_inst.push_back(inst);
        exp_byte.push_back(value);
    endtask

    // random read at address job, then the optional setup and four digit writes
    task automatic build_stream(input int job, input eeprom_display_pkg::bus_byte_t shown);
        eeprom_display_pkg::mem_addr_t addr;
        int                            digit [4];
        addr = 16'(job);
        digit[0] = shown % 10;
        digit[1] = (shown / 10) % 10;
        digit[2] = shown / 100;
        digit[3] = 0;
        expect_cmd(eeprom_display_pkg::INST_START, 8'h00);
        expect_cmd(eeprom_display_pkg::INST_SEND, `EEPROM_DEV_ADDR);
        expect_cmd(eeprom_display_pkg::INST_SEND, addr[15:8]);
        expect_cmd(eeprom_display_pkg::INST_SEND, addr[7:0]);
        expect_cmd(eeprom_display_pkg::INST_START, 8'h00);
        expect_cmd(eeprom_display_pkg::INST_SEND, `EEPROM_DEV_ADDR | 8'h01);
        expect_cmd(eeprom_display_pkg::INST_RECV_NACK, 8'h00);
        expect_cmd(eeprom_display_pkg::INST_STOP, 8'h00);
        if (job == 0) begin
            expect_cmd(eeprom_display_pkg::INST_START, 8'h00);
            expect_cmd(eeprom_display_pkg::INST_SEND, `TM1650_CTRL_ADDR);
            expect_cmd(eeprom_display_pkg::INST_SEND, `TM1650_DISPLAY_ON);
            expect_cmd(eeprom_display_pkg::INST_STOP, 8'h00);
        end
        for (int d = 0; d < `TM1650_DIGITS; d++) begin
            expect_cmd(eeprom_display_pkg::INST_START, 8'h00);
            expect_cmd(eeprom_display_pkg::INST_SEND, 8'(`TM1650_DIGIT0_ADDR - 2 * d));
            expect_cmd(eeprom_display_pkg::INST_SEND, seg_table[digit[d]]);
            expect_cmd(eeprom_display_pkg::INST_STOP, 8'h00);
        end
    endtask

    task automatic pulse_trigger();
        @(posedge in_clk);
        #2 trigger = 1'b1;
        @(posedge in_clk);
        #2 trigger = 1'b0;
    endtask

    task automatic run_job(input int job, input bit extra_triggers);
        int unsigned base;
        int unsigned job_len;
        base = done_count;
        job_len = (job == 0) ? 28 : 24;
        cmd_count = 0;
        test_name = $sformatf("job%0d_byte%0d", job, rx_list[job]);
        build_stream(job, rx_list[job]);
        pulse_trigger();
        if (extra_triggers) begin
            repeat (3) @(posedge in_clk);
            pulse_trigger();
            // this one lands while the writer owns the bus
            wait (done_count >= base + 12);
            pulse_trigger();
        end
        wait (done_count == base + job_len);
        repeat (4) @(posedge in_clk);
    endtask

    // each enable is compared with the head of the expected stream
    always @(negedge in_clk) begin
        if (!in_rst && bus_enable) begin
            if (exp_inst.size() == 0) begin
                fail_run($sformatf("%s: command %s issued when none was expected",
                                   test_name, bus_inst.name()));
            end else begin
                want_inst = exp_inst.pop_front();
                want_byte = exp_byte.pop_front();
                cmd_count++;
                assert (bus_inst == want_inst &&
                        (want_inst != eeprom_display_pkg::INST_SEND || bus_tx_byte == want_byte))
                    else fail_run($sformatf("MISMATCH %s cmd %0d: expected %s %h, actual %s %h",
                                            test_name, cmd_count, want_inst.name(), want_byte,
                                            bus_inst.name(), bus_tx_byte));
            end
        end
    end

    always @(negedge in_clk) begin
        if (uut.u_assertions.any_fail) begin
            fail_run($sformatf("%s: a bus handshake assertion failed", test_name));
        end
    end

    // answers each enable after a random delay
    initial begin : bus_engine
        eeprom_display_pkg::bus_inst_t served;
        int unsigned                   delay;
        bus_done    = 1'b0;
        bus_rx_byte = 8'h00;
        forever begin
            @(negedge in_clk);
            if (!in_rst && bus_enable) begin
                served = bus_inst;
                if (slow_mode) begin
                    delay = $urandom_range(12, 8);
                end else begin
                    delay = $urandom_range(6, 1);
                end
                repeat (delay) @(posedge in_clk);
                #2;
                bus_done = 1'b1;
                if (served == eeprom_display_pkg::INST_RECV_NACK) begin
                    bus_rx_byte = rx_list[recv_count];
                    recv_count++;
                end else begin
                    bus_rx_byte = 8'($urandom);
                end
                done_count++;
                @(posedge in_clk);
                #2 bus_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(timeout_units);
        fail_run("timeout, the jobs did not finish in time");
    end

    initial begin : stimulus
        void'($urandom(32'h9e31_cf75));
        in_rst     = 1'b1;
        trigger    = 1'b0;
        rx_list[0] = 8'd0;
        rx_list[1] = 8'd9;
        rx_list[2] = 8'd137;
        rx_list[3] = 8'd255;
        for (int i = 4; i < jobs; i++) begin
            rx_list[i] = 8'($urandom_range(255, 0));
        end
        repeat (8) @(posedge in_clk);
        #2 in_rst = 1'b0;
        repeat (3) @(posedge in_clk);
        for (int j = 0; j < jobs; j++) begin
            // job 6 runs with long done delays
            slow_mode = (j == 6);
            run_job(j, j == 2 || j == 6);
        end
        repeat (10) @(posedge in_clk);
        if (uut.u_assertions.any_fail || exp_inst.size() != 0) begin
            fail_run("handshake assertions failed or expected commands never came");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== test/eeprom_display_assertions.sv ====
module eeprom_display_assertions (
    input logic                          in_clk,
    input logic                          in_rst,
    input logic                          bus_enable,
    input logic                          bus_done,
    input eeprom_display_pkg::bus_inst_t bus_inst
);

    // a command is out between its enable and its done
    logic outstanding;
    logic pulse_fail = 1'b0;
    logic overlap_fail = 1'b0;
    logic reset_fail = 1'b0;
    logic any_fail;

    assign any_fail = pulse_fail | overlap_fail | reset_fail;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            outstanding <= 1'b0;
        end else if (bus_enable) begin
            outstanding <= 1'b1;
        end else if (bus_done) begin
            outstanding <= 1'b0;
        end
    end

    enable_is_pulse: assert property (@(posedge in_clk) disable iff (in_rst)
        bus_enable |=> !bus_enable)
        else begin
            $error("bus_enable high for two cycles in a row");
            pulse_fail = 1'b1;
        end

    no_enable_while_busy: assert property (@(posedge in_clk) disable iff (in_rst)
        bus_enable |-> !outstanding)
        else begin
            $error("bus_enable while a command is still outstanding");
            overlap_fail = 1'b1;
        end

    // covers every reset cycle and the first cycle after it
    idle_around_reset: assert property (@(posedge in_clk)
        in_rst |=> (!bus_enable && bus_inst == eeprom_display_pkg::INST_NONE))
        else begin
            $error("bus not idle during or right after reset");
            reset_fail = 1'b1;
        end

endmodule

bind eeprom_display_top eeprom_display_assertions u_assertions (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .bus_enable (bus_enable),
    .bus_done   (bus_done),
    .bus_inst   (bus_inst)
);

// ==== logic/eeprom_display_top.sv ====
module eeprom_display_top (
    input  logic                          in_clk,
    input  logic                          in_rst,
    input  logic                          trigger,
    input  logic                          bus_done,
    input  eeprom_display_pkg::bus_byte_t bus_rx_byte,
    output logic                          bus_enable,
    output eeprom_display_pkg::bus_inst_t bus_inst,
    output eeprom_display_pkg::bus_byte_t bus_tx_byte
);

    eeprom_display_pkg::top_state_t state;
    logic                           reader_start;
    logic                           reader_finished;
    logic                           reader_enable;
    eeprom_display_pkg::bus_inst_t  reader_inst;
    eeprom_display_pkg::bus_byte_t  reader_tx_byte;
    eeprom_display_pkg::bus_byte_t  read_byte;
    logic                           writer_start;
    logic                           writer_finished;
    logic                           writer_enable;
    eeprom_display_pkg::bus_inst_t  writer_inst;
    eeprom_display_pkg::bus_byte_t  writer_tx_byte;

    eeprom_byte_reader u_reader (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .start       (reader_start),
        .bus_done    (bus_done),
        .bus_rx_byte (bus_rx_byte),
        .bus_enable  (reader_enable),
        .bus_inst    (reader_inst),
        .bus_tx_byte (reader_tx_byte),
        .read_byte   (read_byte),
        .finished    (reader_finished)
    );

    tm1650_digit_writer u_writer (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .start       (writer_start),
        .show_byte   (read_byte),
        .bus_done    (bus_done),
        .bus_enable  (writer_enable),
        .bus_inst    (writer_inst),
        .bus_tx_byte (writer_tx_byte),
        .finished    (writer_finished)
    );

    // triggers outside idle are dropped, one job at a time
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state        <= eeprom_display_pkg::TOP_IDLE;
            reader_start <= 1'b0;
            writer_start <= 1'b0;
        end else begin
            reader_start <= 1'b0;
            writer_start <= 1'b0;
            case (state)
                eeprom_display_pkg::TOP_IDLE: begin
                    if (trigger) begin
                        state        <= eeprom_display_pkg::TOP_READ;
                        reader_start <= 1'b1;
                    end
                end
                eeprom_display_pkg::TOP_READ: begin
                    if (reader_finished) begin
                        state        <= eeprom_display_pkg::TOP_SHOW;
                        writer_start <= 1'b1;
                    end
                end
                eeprom_display_pkg::TOP_SHOW: begin
                    if (writer_finished) begin
                        state <= eeprom_display_pkg::TOP_IDLE;
                    end
                end
                default: begin
                    state <= eeprom_display_pkg::TOP_IDLE;
                end
            endcase
        end
    end

    // bus goes to whichever stage owns the current state
    always_comb begin
        case (state)
            eeprom_display_pkg::TOP_READ: begin
                bus_enable  = reader_enable;
                bus_inst    = reader_inst;
                bus_tx_byte = reader_tx_byte;
            end
            eeprom_display_pkg::TOP_SHOW: begin
                bus_enable  = writer_enable;
                bus_inst    = writer_inst;
                bus_tx_byte = writer_tx_byte;
            end
            default: begin
                bus_enable  = 1'b0;
                bus_inst    = eeprom_display_pkg::INST_NONE;
                bus_tx_byte = 8'h00;
            end
        endcase
    end

endmodule

// ==== logic/tm1650_digit_writer.sv ====
`include "eeprom_display_config.svh"

module tm1650_digit_writer (
    input  logic                          in_clk,
    input  logic                          in_rst,
    input  logic                          start,
    input  eeprom_display_pkg::bus_byte_t show_byte,
    input  logic                          bus_done,
    output logic                          bus_enable,
    output eeprom_display_pkg::bus_inst_t bus_inst,
    output eeprom_display_pkg::bus_byte_t bus_tx_byte,
    output logic                          finished
);

    eeprom_display_pkg::writer_state_t state;
    eeprom_display_pkg::writer_state_t next_state;
    eeprom_display_pkg::bus_byte_t     shown;
    eeprom_display_pkg::bcd_digit_t    digit_val [`TM1650_DIGITS];
    eeprom_display_pkg::bus_byte_t     digit_addr;
    eeprom_display_pkg::bus_inst_t     cmd_inst;
    eeprom_display_pkg::bus_byte_t     cmd_byte;
    logic [1:0]                        digit_idx;
    logic                              last_digit;
    logic                              setup_done;
    logic                              issued;

    // seven-segment codes without the decimal point
    function automatic eeprom_display_pkg::bus_byte_t seg_code(
        input eeprom_display_pkg::bcd_digit_t d
    );
        case (d)
            4'd0: seg_code = 8'h3F;
            4'd1: seg_code = 8'h06;
            4'd2: seg_code = 8'h5B;
            4'd3: seg_code = 8'h4F;
            4'd4: seg_code = 8'h66;
            4'd5: seg_code = 8'h6D;
            4'd6: seg_code = 8'h7D;
            4'd7: seg_code = 8'h07;
            4'd8: seg_code = 8'h7F;
            4'd9: seg_code = 8'h6F;
            default: seg_code = 8'h00;
        endcase
    endfunction

    // digit 0 holds the ones, a byte never needs digit 3
    always_comb begin
        digit_val[0] = eeprom_display_pkg::bcd_digit_t'(shown % 8'd10);
        digit_val[1] = eeprom_display_pkg::bcd_digit_t'((shown / 8'd10) % 8'd10);
        digit_val[2] = eeprom_display_pkg::bcd_digit_t'(shown / 8'd100);
        digit_val[3] = 4'd0;
    end

    assign digit_addr = `TM1650_DIGIT0_ADDR - {5'd0, digit_idx, 1'b0};
    assign last_digit = (digit_idx == 2'(`TM1650_DIGITS - 1));

    // until setup is done the transaction carries the control command
    always_comb begin
        cmd_inst   = eeprom_display_pkg::INST_SEND;
        cmd_byte   = 8'h00;
        next_state = eeprom_display_pkg::WR_IDLE;
        case (state)
            eeprom_display_pkg::WR_START: begin
                cmd_inst   = eeprom_display_pkg::INST_START;
                next_state = eeprom_display_pkg::WR_ADDR;
            end
            eeprom_display_pkg::WR_ADDR: begin
                cmd_byte   = setup_done ? digit_addr : `TM1650_CTRL_ADDR;
                next_state = eeprom_display_pkg::WR_DATA;
            end
            eeprom_display_pkg::WR_DATA: begin
                cmd_byte   = setup_done ? seg_code(digit_val[digit_idx]) : `TM1650_DISPLAY_ON;
                next_state = eeprom_display_pkg::WR_STOP;
            end
            eeprom_display_pkg::WR_STOP: begin
                cmd_inst = eeprom_display_pkg::INST_STOP;
                if (setup_done && last_digit) begin
                    next_state = eeprom_display_pkg::WR_IDLE;
                end else begin
                    next_state = eeprom_display_pkg::WR_START;
                end
            end
            default: begin
                cmd_inst = eeprom_display_pkg::INST_NONE;
            end
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state      <= eeprom_display_pkg::WR_IDLE;
            issued     <= 1'b0;
            bus_enable <= 1'b0;
            bus_inst   <= eeprom_display_pkg::INST_NONE;
            finished   <= 1'b0;
            digit_idx  <= 2'd0;
            setup_done <= 1'b0;
        end else begin
            bus_enable <= 1'b0;
            bus_inst   <= eeprom_display_pkg::INST_NONE;
            finished   <= 1'b0;
            if (state == eeprom_display_pkg::WR_IDLE) begin
                if (start) begin
                    state     <= eeprom_display_pkg::WR_START;
                    digit_idx <= 2'd0;
                end
            end else if (!issued) begin
                bus_enable <= 1'b1;
                bus_inst   <= cmd_inst;
                issued     <= 1'b1;
            end else if (bus_done) begin
                issued <= 1'b0;
                state  <= next_state;
                if (state == eeprom_display_pkg::WR_STOP) begin
                    if (!setup_done) begin
                        setup_done <= 1'b1;
                    end else if (last_digit) begin
                        finished <= 1'b1;
                    end else begin
                        digit_idx <= digit_idx + 2'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (state == eeprom_display_pkg::WR_IDLE && start) begin
            shown <= show_byte;
        end
        if (state != eeprom_display_pkg::WR_IDLE && !issued) begin
            bus_tx_byte <= cmd_byte;
        end
    end

endmodule

// ==== logic/eeprom_byte_reader.sv ====
`include "eeprom_display_config.svh"

module eeprom_byte_reader (
    input  logic                          in_clk,
    input  logic                          in_rst,
    input  logic                          start,
    input  logic                          bus_done,
    input  eeprom_display_pkg::bus_byte_t bus_rx_byte,
    output logic                          bus_enable,
    output eeprom_display_pkg::bus_inst_t bus_inst,
    output eeprom_display_pkg::bus_byte_t bus_tx_byte,
    output eeprom_display_pkg::bus_byte_t read_byte,
    output logic                          finished
);

    eeprom_display_pkg::reader_state_t state;
    eeprom_display_pkg::reader_state_t next_state;
    eeprom_display_pkg::mem_addr_t     mem_addr;
    eeprom_display_pkg::bus_inst_t     cmd_inst;
    eeprom_display_pkg::bus_byte_t     cmd_byte;
    // command of the current state is out, waiting for its done
    logic                              issued;

    // command and successor for each step of the random read
    always_comb begin
        cmd_inst   = eeprom_display_pkg::INST_SEND;
        cmd_byte   = 8'h00;
        next_state = eeprom_display_pkg::RD_IDLE;
        case (state)
            eeprom_display_pkg::RD_START: begin
                cmd_inst   = eeprom_display_pkg::INST_START;
                next_state = eeprom_display_pkg::RD_DEV_WRITE;
            end
            eeprom_display_pkg::RD_DEV_WRITE: begin
                cmd_byte   = `EEPROM_DEV_ADDR;
                next_state = eeprom_display_pkg::RD_ADDR_HIGH;
            end
            eeprom_display_pkg::RD_ADDR_HIGH: begin
                cmd_byte   = mem_addr[15:8];
                next_state = eeprom_display_pkg::RD_ADDR_LOW;
            end
            eeprom_display_pkg::RD_ADDR_LOW: begin
                cmd_byte   = mem_addr[7:0];
                next_state = eeprom_display_pkg::RD_RESTART;
            end
            eeprom_display_pkg::RD_RESTART: begin
                cmd_inst   = eeprom_display_pkg::INST_START;
                next_state = eeprom_display_pkg::RD_DEV_READ;
            end
            eeprom_display_pkg::RD_DEV_READ: begin
                cmd_byte   = `EEPROM_DEV_ADDR | 8'h01;
                next_state = eeprom_display_pkg::RD_RECV;
            end
            eeprom_display_pkg::RD_RECV: begin
                cmd_inst   = eeprom_display_pkg::INST_RECV_NACK;
                next_state = eeprom_display_pkg::RD_STOP;
            end
            eeprom_display_pkg::RD_STOP: begin
                cmd_inst   = eeprom_display_pkg::INST_STOP;
                next_state = eeprom_display_pkg::RD_IDLE;
            end
            default: begin
                cmd_inst = eeprom_display_pkg::INST_NONE;
            end
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state      <= eeprom_display_pkg::RD_IDLE;
            issued     <= 1'b0;
            bus_enable <= 1'b0;
            bus_inst   <= eeprom_display_pkg::INST_NONE;
            finished   <= 1'b0;
            mem_addr   <= 16'd0;
        end else begin
            bus_enable <= 1'b0;
            bus_inst   <= eeprom_display_pkg::INST_NONE;
            finished   <= 1'b0;
            if (state == eeprom_display_pkg::RD_IDLE) begin
                if (start) begin
                    state <= eeprom_display_pkg::RD_START;
                end
            end else if (!issued) begin
                bus_enable <= 1'b1;
                bus_inst   <= cmd_inst;
                issued     <= 1'b1;
                // next job reads the following location
                if (state == eeprom_display_pkg::RD_ADDR_LOW) begin
                    mem_addr <= mem_addr + 16'd1;
                end
            end else if (bus_done) begin
                issued   <= 1'b0;
                state    <= next_state;
                finished <= (state == eeprom_display_pkg::RD_STOP);
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (state != eeprom_display_pkg::RD_IDLE && !issued) begin
            bus_tx_byte <= cmd_byte;
        end
        if (state == eeprom_display_pkg::RD_RECV && issued && bus_done) begin
            read_byte <= bus_rx_byte;
        end
    end

endmodule

// ==== logic/eeprom_display_pkg.sv ====
package eeprom_display_pkg;

    typedef logic [7:0] bus_byte_t;
    typedef logic [15:0] mem_addr_t;
    typedef logic [3:0] bcd_digit_t;

    // byte-level commands understood by the bus engine
    typedef enum logic [2:0] {
        INST_NONE      = 3'd0,
        INST_START     = 3'd1,
        INST_SEND      = 3'd2,
        INST_RECV_NACK = 3'd3,
        INST_STOP      = 3'd4
    } bus_inst_t;

    typedef enum logic [3:0] {
        RD_IDLE,
        RD_START,
        RD_DEV_WRITE,
        RD_ADDR_HIGH,
        RD_ADDR_LOW,
        RD_RESTART,
        RD_DEV_READ,
        RD_RECV,
        RD_STOP
    } reader_state_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_START,
        WR_ADDR,
        WR_DATA,
        WR_STOP
    } writer_state_t;

    typedef enum logic [1:0] {
        TOP_IDLE,
        TOP_READ,
        TOP_SHOW
    } top_state_t;

endpackage

// ==== logic/eeprom_display_config.svh ====
`ifndef EEPROM_DISPLAY_CONFIG_SVH
`define EEPROM_DISPLAY_CONFIG_SVH

// serial eeprom device address, write form
// the read form sets bit 0
`define EEPROM_DEV_ADDR 8'hA0

// tm1650 control register address
`define TM1650_CTRL_ADDR 8'h48

// brightness level and display on
`define TM1650_DISPLAY_ON 8'h15

// address of digit 0
// each higher digit sits 2 below: 6C, 6A, 68
`define TM1650_DIGIT0_ADDR 8'h6E

// digits on the display module
`define TM1650_DIGITS 4

`endif
